// ==== all.f ====
+incdir+include
rtl/eq_sample_pkg.sv
rtl/eq_band_pkg.sv
rtl/eq_ifs.sv
rtl/adc_capture.sv
rtl/sample_window.sv
rtl/band_dispatch.sv
rtl/gain_lane.sv
rtl/band_writeback.sv
rtl/eq_top.sv
verif/eq_sva.sv
verif/eq_tb.sv

// ==== include/eq_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing macros for the equaliser datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef EQ_CONFIG_SVH
`define EQ_CONFIG_SVH

// sample and gain width in bits
`define EQ_SAMPLE_W 16

// number of entries held in the sample window
`define EQ_WINDOW_DEPTH 64

// entries scaled by one band command and number of lanes
`define EQ_LANES 4

// valid bands run from 1 up to this count
`define EQ_BANDS 16

`endif

// ==== rtl/adc_capture.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adc_capture edge detect and sample centring
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

module adc_capture
    import eq_sample_pkg::*;
(
    input  logic                    clock,
    input  logic                    fft_reset,
    input  logic                    adc_ready,
    input  logic [`EQ_SAMPLE_W-1:0] adc_sample,
    input  logic                    sample_accept,
    output logic                    sample_pending,
    output sample_t                 pending_sample
);

    // offset binary mid scale maps to zero
    localparam logic [`EQ_SAMPLE_W-1:0] mid_scale = {1'b1, {(`EQ_SAMPLE_W-1){1'b0}}};

    logic adc_ready_q;
    logic adc_edge;

    // one cycle pulse on the low to high step of adc_ready
    assign adc_edge = adc_ready && !adc_ready_q;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            adc_ready_q    <= 1'b0;
            sample_pending <= 1'b0;
        end else begin
            adc_ready_q <= adc_ready;
            // a fresh edge wins over the accept of the older sample
            if (adc_edge) begin
                sample_pending <= 1'b1;
            end else if (sample_accept) begin
                sample_pending <= 1'b0;
            end
        end
    end

    // held until the window takes it
    always_ff @(posedge clock) begin
        if (adc_edge) begin
            pending_sample <= sample_t'(adc_sample - mid_scale);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/band_dispatch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// band_dispatch command check and operand fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

module band_dispatch
    import eq_sample_pkg::*;
    import eq_band_pkg::*;
(
    input  logic        clock,
    input  logic        fft_reset,
    input  logic        band_valid,
    input  band_index_t band_index,
    input  gain_t       band_gain,
    window_if.reader    win,
    band_if.source      band
);

    logic       index_ok;
    logic       cmd_ok;
    win_index_t band_base;

    // band 0 and anything past the last band are dropped
    assign index_ok = (band_index != '0) && (band_index <= band_index_t'(`EQ_BANDS));
    assign cmd_ok   = band_valid && index_ok;

    // band n starts at entry (n - 1) * lanes
    assign band_base   = win_index_t'(band_index - band_index_t'(1)) * win_index_t'(`EQ_LANES);
    assign win.rd_base = band_base;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            band.issue <= 1'b0;
        end else begin
            band.issue <= cmd_ok;
        end
    end

    // window snapshot taken at the command edge
    always_ff @(posedge clock) begin
        if (cmd_ok) begin
            band.base     <= band_base;
            band.gain     <= band_gain;
            band.operands <= win.rd_bins;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/band_writeback.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// band_writeback result write and done pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module band_writeback
    import eq_sample_pkg::*;
(
    input  logic      clock,
    input  logic      fft_reset,
    band_if.sink      band,
    window_if.writer  win,
    output logic      band_done
);

    // issue and base delayed to meet the lane results
    logic       write_pending;
    win_index_t write_base;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            write_pending <= 1'b0;
            band_done     <= 1'b0;
        end else begin
            write_pending <= band.issue;
            // done follows the cycle of the window write
            band_done     <= write_pending;
        end
    end

    // back to back commands each carry their own base
    always_ff @(posedge clock) begin
        if (band.issue) begin
            write_base <= band.base;
        end
    end

    assign win.wr_en   = write_pending;
    assign win.wr_base = write_base;
    assign win.wr_bins = band.results;

endmodule

`default_nettype wire

// ==== rtl/eq_band_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// band command and gain types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

package eq_band_pkg;

    // band number valid from 1 to EQ_BANDS
    typedef logic [$clog2(`EQ_BANDS+1)-1:0] band_index_t;

    // Q15 gain so 16'h7fff sits just under unity
    typedef logic signed [`EQ_SAMPLE_W-1:0] gain_t;

endpackage

`default_nettype wire

// ==== rtl/eq_ifs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// window_if for band fetch and write-back
// band_if between dispatch, lanes and write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

interface window_if
    import eq_sample_pkg::*;
();
    // four-entry read for the band fetch
    win_index_t rd_base;
    lane_bins_t rd_bins;
    // four-entry write of scaled results
    logic       wr_en;
    win_index_t wr_base;
    lane_bins_t wr_bins;

    modport reader (output rd_base, input rd_bins);
    modport writer (output wr_en, output wr_base, output wr_bins);
    modport store (input rd_base, output rd_bins, input wr_en, input wr_base, input wr_bins);
endinterface

interface band_if
    import eq_sample_pkg::*;
    import eq_band_pkg::*;
();
    // one cycle strobe per accepted band command
    logic       issue;
    win_index_t base;
    gain_t      gain;
    lane_bins_t operands;
    // lane i owns element i
    lane_bins_t results;

    modport source (output issue, output base, output gain, output operands);
    modport lane (input gain, input operands, output results);
    modport sink (input issue, input base, input results);
endinterface

`default_nettype wire

// ==== rtl/eq_sample_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample and window position types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

package eq_sample_pkg;

    // centred sample or bin read as Q15 by the lanes
    typedef logic signed [`EQ_SAMPLE_W-1:0] sample_t;

    // window position where 0 is the newest entry
    typedef logic [$clog2(`EQ_WINDOW_DEPTH)-1:0] win_index_t;

    // one band of entries and lane i holds entry base + i
    typedef sample_t [`EQ_LANES-1:0] lane_bins_t;

endpackage

`default_nettype wire

// ==== rtl/eq_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eq_top equaliser datapath top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

module eq_top
    import eq_sample_pkg::*;
    import eq_band_pkg::*;
(
    input  logic                    clock,
    input  logic                    fft_reset,
    input  logic                    adc_ready,
    input  logic [`EQ_SAMPLE_W-1:0] adc_sample,
    input  logic                    band_valid,
    input  band_index_t             band_index,
    input  gain_t                   band_gain,
    input  logic                    audio_req,
    input  win_index_t              read_index,
    output logic                    band_done,
    output sample_t                 audio_out,
    output logic                    sample_ready,
    output sample_t                 read_data
);

    // capture to window handoff
    logic    sample_pending;
    logic    sample_accept;
    sample_t pending_sample;

    window_if win_bus ();
    band_if   band_bus ();

    adc_capture u_adc_capture (
        .clock          (clock),
        .fft_reset      (fft_reset),
        .adc_ready      (adc_ready),
        .adc_sample     (adc_sample),
        .sample_accept  (sample_accept),
        .sample_pending (sample_pending),
        .pending_sample (pending_sample)
    );

    sample_window u_sample_window (
        .clock          (clock),
        .fft_reset      (fft_reset),
        .win            (win_bus),
        .sample_pending (sample_pending),
        .pending_sample (pending_sample),
        .sample_accept  (sample_accept),
        .read_index     (read_index),
        .read_data      (read_data),
        .audio_req      (audio_req),
        .audio_out      (audio_out),
        .sample_ready   (sample_ready)
    );

    band_dispatch u_band_dispatch (
        .clock      (clock),
        .fft_reset  (fft_reset),
        .band_valid (band_valid),
        .band_index (band_index),
        .band_gain  (band_gain),
        .win        (win_bus),
        .band       (band_bus)
    );

    // one lane per entry of the band
    for (genvar i = 0; i < `EQ_LANES; i++) begin : g_lane
        gain_lane #(
            .lane_sel (i)
        ) u_gain_lane (
            .clock (clock),
            .band  (band_bus)
        );
    end

    band_writeback u_band_writeback (
        .clock     (clock),
        .fft_reset (fft_reset),
        .band      (band_bus),
        .win       (win_bus),
        .band_done (band_done)
    );

endmodule

`default_nettype wire

// ==== rtl/gain_lane.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gain_lane Q15 multiply with saturation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

module gain_lane
    import eq_sample_pkg::*;
#(
    parameter int lane_sel = 0
) (
    input  logic clock,
    band_if.lane band
);

    localparam int sample_w = `EQ_SAMPLE_W;
    localparam int frac_bits = sample_w - 1;
    localparam sample_t sat_max = {1'b0, {(sample_w-1){1'b1}}};
    localparam sample_t sat_min = {1'b1, {(sample_w-1){1'b0}}};

    sample_t                    operand;
    logic signed [2*sample_w-1:0] product;
    logic signed [2*sample_w-1:0] scaled;
    logic                       in_range;

    assign operand = band.operands[lane_sel];

    // full precision signed product
    assign product = operand * band.gain;

    // truncating shift back to Q15
    assign scaled = product >>> frac_bits;

    // fits when every bit above the sample sign copies it
    // only -1 x -1 ends up outside
    assign in_range = (scaled[2*sample_w-1:sample_w-1] == {(sample_w+1){scaled[sample_w-1]}});

    always_ff @(posedge clock) begin
        if (in_range) begin
            band.results[lane_sel] <= scaled[sample_w-1:0];
        end else begin
            band.results[lane_sel] <= scaled[2*sample_w-1] ? sat_min : sat_max;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sample_window.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample_window storage with band fetch/write
// plus read port and audio output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

module sample_window
    import eq_sample_pkg::*;
(
    input  logic       clock,
    input  logic       fft_reset,
    window_if.store    win,
    input  logic       sample_pending,
    input  sample_t    pending_sample,
    output logic       sample_accept,
    input  win_index_t read_index,
    output sample_t    read_data,
    input  logic       audio_req,
    output sample_t    audio_out,
    output logic       sample_ready
);

    // index 0 newest and the last index oldest
    sample_t entries [`EQ_WINDOW_DEPTH];

    // band write has priority so the sample waits a cycle
    assign sample_accept = sample_pending && !win.wr_en;

    // four adjacent entries for the band fetch
    always_comb begin
        for (int i = 0; i < `EQ_LANES; i++) begin
            win.rd_bins[i] = entries[win.rd_base + win_index_t'(i)];
        end
    end

    // random access tap replacing the wide bin bus
    assign read_data = entries[read_index];

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            for (int i = 0; i < `EQ_WINDOW_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (win.wr_en) begin
            // scaled band goes back in place
            for (int i = 0; i < `EQ_LANES; i++) begin
                entries[win.wr_base + win_index_t'(i)] <= win.wr_bins[i];
            end
        end else if (sample_accept) begin
            // shift everything up one and drop the oldest
            entries[0] <= pending_sample;
            for (int i = 1; i < `EQ_WINDOW_DEPTH; i++) begin
                entries[i] <= entries[i-1];
            end
        end
    end

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            sample_ready <= 1'b0;
        end else begin
            sample_ready <= audio_req;
        end
    end

    // oldest entry as it stood before this edge's shift or write
    always_ff @(posedge clock) begin
        if (audio_req) begin
            audio_out <= entries[`EQ_WINDOW_DEPTH-1];
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the equaliser testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module eq_tb -f all.f -o eq_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/eq_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Done: no errors"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== verif/eq_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eq_sva port assertions, bound into eq_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

module eq_sva
    import eq_sample_pkg::*;
    import eq_band_pkg::*;
(
    input logic        clock,
    input logic        fft_reset,
    input logic        band_valid,
    input band_index_t band_index,
    input logic        audio_req,
    input logic        sample_ready,
    input logic        band_done,
    input sample_t     audio_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // ready held over two edges needs two requests in a row
    held_ready_needs_requests: assert property (
        @(posedge clock) disable iff (fft_reset)
        (sample_ready && $past(sample_ready)) |-> ($past(audio_req) && $past(audio_req, 2))
    ) else $error("sample_ready held high without two consecutive audio requests");

    // done is seen three sampled edges after the command edge
    done_follows_command: assert property (
        @(posedge clock) disable iff (fft_reset)
        band_done |-> ($past(band_valid, 3) && ($past(band_index, 3) >= 1)
                       && ($past(band_index, 3) <= `EQ_BANDS))
    ) else $error("band_done without a valid band command before it");

    audio_known_on_ready: assert property (
        @(posedge clock) disable iff (fft_reset)
        sample_ready |-> !$isunknown(audio_out)
    ) else $error("audio_out unknown while sample_ready is high");

endmodule

bind eq_top eq_sva u_eq_sva (
    .clock        (clock),
    .fft_reset    (fft_reset),
    .band_valid   (band_valid),
    .band_index   (band_index),
    .audio_req    (audio_req),
    .sample_ready (sample_ready),
    .band_done    (band_done),
    .audio_out    (audio_out)
);

`default_nettype wire

// ==== verif/eq_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eq_tb testbench for eq_top with window model,
// stimulus table, value checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "eq_config.svh"

module eq_tb
    import eq_sample_pkg::*;
    import eq_band_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_period   = 20;
    localparam int drive_delay    = 2;
    localparam int reset_cycles   = 5;
    localparam int cycles_per_row = 10;
    localparam int done_timeout   = 8;

    typedef enum int {op_sample, op_band, op_audio, op_check, op_pair} op_t;

    // a = sample (negative for random) or band, b = gain, c/d = second band, e = sample
    typedef struct packed {
        op_t op;
        int  arg_a;
        int  arg_b;
        int  arg_c;
        int  arg_d;
        int  arg_e;
    } row_t;

    logic                    clock;
    logic                    fft_reset;
    logic                    adc_ready;
    logic [`EQ_SAMPLE_W-1:0] adc_sample;
    logic                    band_valid;
    band_index_t             band_index;
    gain_t                   band_gain;
    logic                    audio_req;
    win_index_t              read_index;
    logic                    band_done;
    sample_t                 audio_out;
    logic                    sample_ready;
    sample_t                 read_data;

    // reference copy of the window, index 0 newest
    sample_t ref_win [`EQ_WINDOW_DEPTH];
    row_t    stim [$];
    integer  seed = 32'h2744_1b9f;

    eq_top dut (
        .clock        (clock),
        .fft_reset    (fft_reset),
        .adc_ready    (adc_ready),
        .adc_sample   (adc_sample),
        .band_valid   (band_valid),
        .band_index   (band_index),
        .band_gain    (band_gain),
        .audio_req    (audio_req),
        .read_index   (read_index),
        .band_done    (band_done),
        .audio_out    (audio_out),
        .sample_ready (sample_ready),
        .read_data    (read_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2) clock = ~clock;
        end
    end

    // offset binary to signed, mid scale lands on zero
    function automatic sample_t centre(input logic [15:0] raw);
        int value;
        value = int'(raw) - 32768;
        return sample_t'(value);
    endfunction

    function automatic logic [15:0] pick_raw(input int arg);
        if (arg < 0) begin
            return 16'($random(seed));
        end
        return arg[15:0];
    endfunction

    // Q15 product, arithmetic shift by 15, then clamp
    function automatic sample_t lane_result(input sample_t entry, input gain_t gain);
        int product;
        product = int'(entry) * int'(gain);
        product = product >>> 15;
        if (product > 32767) begin
            product = 32767;
        end else if (product < -32768) begin
            product = -32768;
        end
        return sample_t'(product);
    endfunction

    function automatic bit band_in_range(input int idx);
        return (idx >= 1) && (idx <= `EQ_BANDS);
    endfunction

    function automatic void shift_reference(input sample_t value);
        for (int i = `EQ_WINDOW_DEPTH - 1; i > 0; i--) begin
            ref_win[i] = ref_win[i-1];
        end
        ref_win[0] = value;
    endfunction

    // bad bands leave the model alone
    function automatic void scale_reference(input int idx, input gain_t gain);
        int base;
        if (band_in_range(idx)) begin
            base = (idx - 1) * `EQ_LANES;
            for (int i = 0; i < `EQ_LANES; i++) begin
                ref_win[base+i] = lane_result(ref_win[base+i], gain);
            end
        end
    endfunction

    function automatic void add_row(input op_t op, input int a, input int b,
                                    input int c, input int d, input int e);
        row_t row;
        row.op    = op;
        row.arg_a = a;
        row.arg_b = b;
        row.arg_c = c;
        row.arg_d = d;
        row.arg_e = e;
        stim.push_back(row);
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s read %h, expected %h",
                                     $time, what, actual, expected));
        end
    endtask

    // inputs change a little after the rising edge
    task automatic wait_drive_point();
        @(posedge clock);
        #(drive_delay);
    endtask

    task automatic send_sample(input int arg);
        logic [15:0] raw;
        raw = pick_raw(arg);
        adc_ready  = 1'b1;
        adc_sample = raw;
        // edge E0 sets the pending sample
        wait_drive_point();
        adc_ready = 1'b0;
        // no band write, so the shift happens here
        wait_drive_point();
        shift_reference(centre(raw));
        read_index = '0;
        @(negedge clock);
        check_value("newest entry", read_data, ref_win[0]);
        wait_drive_point();
    endtask

    task automatic issue_band(input int idx, input int gain);
        int cycle;
        bit seen;
        band_valid = 1'b1;
        band_index = band_index_t'(idx);
        band_gain  = gain_t'(gain);
        wait_drive_point();
        band_valid = 1'b0;
        scale_reference(idx, gain_t'(gain));
        seen  = 1'b0;
        cycle = 0;
        // count negedges after E0 until band_done shows up
        while (!seen && cycle < done_timeout) begin
            @(negedge clock);
            if (band_done) begin
                seen = 1'b1;
            end else begin
                cycle++;
            end
        end
        if (band_in_range(idx)) begin
            if (!seen) begin
                report_failure($sformatf("band %0d: band_done never arrived", idx));
            end
            check_value("band_done delay", cycle, 2);
            @(negedge clock);
            check_value("band_done width", band_done, 1'b0);
        end else begin
            check_value("band_done on bad band", seen, 1'b0);
        end
        wait_drive_point();
    endtask

    // two commands on consecutive edges, sample edge on the second
    task automatic run_band_pair(input int idx_a, input int gain_a, input int idx_b,
                                 input int gain_b, input int arg);
        logic [15:0] raw;
        int          done_seen;
        int          cycle;
        raw        = pick_raw(arg);
        read_index = '0;
        band_valid = 1'b1;
        band_index = band_index_t'(idx_a);
        band_gain  = gain_t'(gain_a);
        wait_drive_point();
        band_index = band_index_t'(idx_b);
        band_gain  = gain_t'(gain_b);
        adc_ready  = 1'b1;
        adc_sample = raw;
        wait_drive_point();
        band_valid = 1'b0;
        adc_ready  = 1'b0;
        // both fetches saw the window before the shift
        scale_reference(idx_a, gain_t'(gain_a));
        scale_reference(idx_b, gain_t'(gain_b));
        shift_reference(centre(raw));
        done_seen = 0;
        cycle     = 0;
        while (done_seen < 2 && cycle < done_timeout) begin
            @(negedge clock);
            if (band_done) begin
                done_seen++;
            end
            cycle++;
        end
        if (done_seen < 2) begin
            report_failure("band pair: band_done did not pulse twice");
        end
        // both writes done, sample still waiting
        check_value("index 0 before shift", read_data, ref_win[1]);
        wait_drive_point();
        @(negedge clock);
        check_value("sample after writes", read_data, ref_win[0]);
        wait_drive_point();
    endtask

    task automatic request_audio();
        sample_t expected;
        expected  = ref_win[`EQ_WINDOW_DEPTH-1];
        audio_req = 1'b1;
        wait_drive_point();
        audio_req = 1'b0;
        @(negedge clock);
        check_value("sample_ready", sample_ready, 1'b1);
        check_value("audio_out", audio_out, expected);
        @(negedge clock);
        check_value("sample_ready drop", sample_ready, 1'b0);
        wait_drive_point();
    endtask

    task automatic compare_window();
        for (int i = 0; i < `EQ_WINDOW_DEPTH; i++) begin
            read_index = win_index_t'(i);
            @(negedge clock);
            check_value($sformatf("entry %0d", i), read_data, ref_win[i]);
            wait_drive_point();
        end
    endtask

    function automatic void build_table();
        add_row(op_check, 0, 0, 0, 0, 0);
        for (int i = 0; i < `EQ_WINDOW_DEPTH; i++) begin
            add_row(op_sample, -1, 0, 0, 0, 0);
        end
        add_row(op_check, 0, 0, 0, 0, 0);
        add_row(op_band, 1, 'h7fff, 0, 0, 0);
        add_row(op_band, 7, 'h4000, 0, 0, 0);
        add_row(op_band, 16, 'hc000, 0, 0, 0);
        add_row(op_band, 7, 'h0000, 0, 0, 0);
        add_row(op_check, 0, 0, 0, 0, 0);
        // out of range bands
        add_row(op_band, 0, 'h7fff, 0, 0, 0);
        add_row(op_band, 17, 'h4000, 0, 0, 0);
        add_row(op_band, 31, 'hc000, 0, 0, 0);
        add_row(op_audio, 0, 0, 0, 0, 0);
        // raw zero centres to -32768, then -1.0 gain saturates
        add_row(op_sample, 0, 0, 0, 0, 0);
        add_row(op_band, 1, 'h8000, 0, 0, 0);
        add_row(op_pair, 3, 'h4000, 12, 'hc000, -1);
        add_row(op_audio, 0, 0, 0, 0, 0);
        add_row(op_check, 0, 0, 0, 0, 0);
    endfunction

    initial begin
        int wd_cycles;
        fft_reset  = 1'b1;
        adc_ready  = 1'b0;
        adc_sample = '0;
        band_valid = 1'b0;
        band_index = '0;
        band_gain  = '0;
        audio_req  = 1'b0;
        read_index = '0;
        for (int i = 0; i < `EQ_WINDOW_DEPTH; i++) begin
            ref_win[i] = '0;
        end
        build_table();
        wd_cycles = stim.size() * cycles_per_row + reset_cycles;
        // watchdog sized from the table length
        fork
            begin
                #(wd_cycles * clock_period);
                report_failure($sformatf("watchdog: run did not finish in %0d cycles",
                                         wd_cycles));
            end
        join_none
        repeat (reset_cycles) @(posedge clock);
        #(drive_delay);
        fft_reset = 1'b0;
        @(negedge clock);
        check_value("band_done after reset", band_done, 1'b0);
        check_value("sample_ready after reset", sample_ready, 1'b0);
        wait_drive_point();
        foreach (stim[n]) begin
            case (stim[n].op)
                op_sample: send_sample(stim[n].arg_a);
                op_band:   issue_band(stim[n].arg_a, stim[n].arg_b);
                op_audio:  request_audio();
                op_check:  compare_window();
                op_pair:   run_band_pair(stim[n].arg_a, stim[n].arg_b, stim[n].arg_c,
                                         stim[n].arg_d, stim[n].arg_e);
                default:   report_failure("stimulus table holds an unknown operation");
            endcase
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
